// File: verilog/priv_macros.svh
`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

// data path width
`define XLEN 32

// machine-mode csr addresses
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MHARTID  12'hf14

// mstatus bit positions, mpp is two bits wide from MPP_LO
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7
`define MSTATUS_MPP_LO 11

// only the machine software, timer and external enables exist
`define MIE_MASK 32'h0000_0888

// mxl = 1 (rv32), extensions i and u
`define MISA_VALUE 32'h4010_0100

// synchronous exception codes
`define CAUSE_ILLEGAL 5'd2
`define CAUSE_BREAK   5'd3
`define CAUSE_ECALL_U 5'd8
`define CAUSE_ECALL_M 5'd11

`define OPC_SYSTEM 7'b1110011

`endif

// File: verilog/isa_pkg.sv
`default_nettype none
`include "priv_macros.svh"

package isa_pkg;

   // i-type layout of the six csr instructions
   // rs1 doubles as the 5-bit zero-extended immediate
   typedef struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } csr_fmt_t;

   // r-type layout, ecall / ebreak / mret are told apart by funct7 and rs2
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } priv_fmt_t;

   // same 32-bit word, two readings
   typedef union packed {
      csr_fmt_t  csr_view;
      priv_fmt_t priv_view;
   } instr_word_u;

   // immediate csr forms fold onto the register forms
   typedef enum logic [3:0] {
      OP_CSRRW,
      OP_CSRRS,
      OP_CSRRC,
      OP_ECALL,
      OP_EBREAK,
      OP_MRET,
      OP_ILLEGAL
   } sys_op_t;

endpackage
`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none
`include "priv_macros.svh"

package csr_pkg;

   // only user and machine mode exist, encodings follow mstatus.mpp
   typedef enum logic [1:0] {
      MODE_U = 2'd0,
      MODE_M = 2'd3
   } priv_mode_t;

   // 12-bit csr number from the instruction
   // bits 11:10 both set marks a read-only csr
   typedef logic [11:0] csr_addr_t;

   // exception code as held in mcause, no interrupt bit
   typedef logic [4:0] cause_t;

endpackage
`default_nettype wire

// File: verilog/sys_decode.sv
`default_nettype none
`include "priv_macros.svh"

module sys_decode (
   input  wire                       clk,
   input  wire                       rstn,
   input  wire                       instr_valid,
   input  wire isa_pkg::instr_word_u instr_word,
   input  wire [`XLEN-1:0]           instr_pc,
   input  wire [`XLEN-1:0]           rs1_value,
   output logic                      dec_valid,
   output isa_pkg::sys_op_t          dec_op,
   output csr_pkg::csr_addr_t        dec_csr,
   output logic [4:0]                dec_rd,
   output logic [`XLEN-1:0]          dec_operand,
   output logic                      dec_csr_write,
   output logic [`XLEN-1:0]          dec_pc,
   output logic [`XLEN-1:0]          dec_word
);
   import isa_pkg::*;

   csr_fmt_t         csr_view;
   priv_fmt_t        priv_view;
   sys_op_t          op;
   logic             csr_form;
   logic             csr_write;
   logic [`XLEN-1:0] operand;

   assign csr_view  = instr_word.csr_view;
   assign priv_view = instr_word.priv_view;

   //////////////////////////////////////////////////
   // classify
   always_comb begin
      op = OP_ILLEGAL;
      if (csr_view.opcode == `OPC_SYSTEM) begin
         case (csr_view.funct3)
            3'b001, 3'b101: op = OP_CSRRW;
            3'b010, 3'b110: op = OP_CSRRS;
            3'b011, 3'b111: op = OP_CSRRC;
            3'b000: begin
               // privileged forms need rd and rs1 zero
               if (priv_view.rd == 5'd0 && priv_view.rs1 == 5'd0) begin
                  if (priv_view.funct7 == 7'b0000000 && priv_view.rs2 == 5'd0) begin
                     op = OP_ECALL;
                  end else if (priv_view.funct7 == 7'b0000000 && priv_view.rs2 == 5'd1) begin
                     op = OP_EBREAK;
                  end else if (priv_view.funct7 == 7'b0011000 && priv_view.rs2 == 5'd2) begin
                     op = OP_MRET;
                  end
               end
            end
            default: op = OP_ILLEGAL;
         endcase
      end
   end

   assign csr_form = (op == OP_CSRRW) || (op == OP_CSRRS) || (op == OP_CSRRC);

   // funct3[2] picks the immediate forms
   assign operand = csr_view.funct3[2] ? {{(`XLEN-5){1'b0}}, csr_view.rs1} : rs1_value;

   // set/clear with x0 or zero imm is a pure read
   assign csr_write = csr_form && ((op == OP_CSRRW) || (csr_view.rs1 != 5'd0));

   //////////////////////////////////////////////////
   // stage register
   always_ff @(posedge clk) begin
      if (rstn) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid) begin
         dec_op        <= op;
         dec_csr       <= csr_view.csr;
         dec_rd        <= csr_view.rd;
         dec_operand   <= operand;
         dec_csr_write <= csr_write;
         dec_pc        <= instr_pc;
         dec_word      <= instr_word;
      end
   end

endmodule
`default_nettype wire

// File: verilog/csr_execute.sv
`default_nettype none
`include "priv_macros.svh"

module csr_execute (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     dec_valid,
   input  wire isa_pkg::sys_op_t   dec_op,
   input  wire csr_pkg::csr_addr_t dec_csr,
   input  wire [4:0]               dec_rd,
   input  wire [`XLEN-1:0]         dec_operand,
   input  wire                     dec_csr_write,
   input  wire [`XLEN-1:0]         dec_pc,
   input  wire [`XLEN-1:0]         dec_word,
   output logic                    ex_valid,
   output logic [4:0]              ex_rd,
   output logic [`XLEN-1:0]        ex_old_value,
   output logic                    ex_trap,
   output logic [`XLEN-1:0]        ex_target,
   output csr_pkg::priv_mode_t     cpu_mode
);
   import isa_pkg::*;
   import csr_pkg::*;

   // csr file, mstatus kept as its three live fields
   logic             mstatus_mie;
   logic             mstatus_mpie;
   priv_mode_t       mstatus_mpp;
   logic [`XLEN-1:0] mie;
   logic [`XLEN-1:0] mtvec;
   logic [`XLEN-1:0] mscratch;
   logic [`XLEN-1:0] mepc;
   cause_t           mcause;
   logic [`XLEN-1:0] mtval;

   logic [`XLEN-1:0] mstatus_value;
   logic [`XLEN-1:0] csr_rdata;
   logic [`XLEN-1:0] csr_wdata;
   logic             csr_known;
   logic             csr_op;
   logic             csr_legal;
   logic             illegal;
   logic             take_trap;
   logic             do_mret;
   logic             do_write;
   cause_t           trap_cause;

   always_comb begin
      mstatus_value = '0;
      mstatus_value[`MSTATUS_MIE]       = mstatus_mie;
      mstatus_value[`MSTATUS_MPIE]      = mstatus_mpie;
      mstatus_value[`MSTATUS_MPP_LO+:2] = mstatus_mpp;
   end

   //////////////////////////////////////////////////
   // read side and legality
   always_comb begin
      csr_known = 1'b1;
      csr_rdata = '0;
      case (dec_csr)
         `CSR_MSTATUS:  csr_rdata = mstatus_value;
         `CSR_MISA:     csr_rdata = `MISA_VALUE;
         `CSR_MIE:      csr_rdata = mie;
         `CSR_MTVEC:    csr_rdata = mtvec;
         `CSR_MSCRATCH: csr_rdata = mscratch;
         `CSR_MEPC:     csr_rdata = mepc;
         `CSR_MCAUSE:   csr_rdata = {{(`XLEN-5){1'b0}}, mcause};
         `CSR_MTVAL:    csr_rdata = mtval;
         // single hart, id 0
         `CSR_MHARTID:  csr_rdata = '0;
         default:       csr_known = 1'b0;
      endcase
   end

   assign csr_op    = (dec_op == OP_CSRRW) || (dec_op == OP_CSRRS) || (dec_op == OP_CSRRC);
   assign csr_legal = csr_known && (cpu_mode == MODE_M) && !(&dec_csr[11:10] && dec_csr_write);

   // mret outside M is illegal as well
   assign illegal = (dec_op == OP_ILLEGAL) || (csr_op && !csr_legal) ||
                    ((dec_op == OP_MRET) && (cpu_mode != MODE_M));

   assign take_trap = dec_valid && (illegal || (dec_op == OP_ECALL) || (dec_op == OP_EBREAK));
   assign do_mret   = dec_valid && (dec_op == OP_MRET) && (cpu_mode == MODE_M);
   assign do_write  = dec_valid && csr_op && csr_legal && dec_csr_write;

   always_comb begin
      if (illegal) begin
         trap_cause = `CAUSE_ILLEGAL;
      end else if (dec_op == OP_EBREAK) begin
         trap_cause = `CAUSE_BREAK;
      end else if (cpu_mode == MODE_U) begin
         trap_cause = `CAUSE_ECALL_U;
      end else begin
         trap_cause = `CAUSE_ECALL_M;
      end
   end

   // read-modify-write
   always_comb begin
      case (dec_op)
         OP_CSRRS: csr_wdata = csr_rdata | dec_operand;
         OP_CSRRC: csr_wdata = csr_rdata & ~dec_operand;
         default:  csr_wdata = dec_operand;
      endcase
   end

   //////////////////////////////////////////////////
   // state update
   always_ff @(posedge clk) begin
      if (rstn) begin
         cpu_mode     <= MODE_M;
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mstatus_mpp  <= MODE_U;
         mie          <= '0;
         mtvec        <= '0;
         mscratch     <= '0;
         mepc         <= '0;
         mcause       <= '0;
         mtval        <= '0;
      end else if (take_trap) begin
         mepc         <= dec_pc;
         mcause       <= trap_cause;
         mtval        <= illegal ? dec_word : '0;
         mstatus_mpie <= mstatus_mie;
         mstatus_mie  <= 1'b0;
         mstatus_mpp  <= cpu_mode;
         cpu_mode     <= MODE_M;
      end else if (do_mret) begin
         cpu_mode     <= mstatus_mpp;
         mstatus_mie  <= mstatus_mpie;
         mstatus_mpie <= 1'b1;
         mstatus_mpp  <= MODE_U;
      end else if (do_write) begin
         case (dec_csr)
            `CSR_MSTATUS: begin
               mstatus_mie  <= csr_wdata[`MSTATUS_MIE];
               mstatus_mpie <= csr_wdata[`MSTATUS_MPIE];
               // warl, anything but 11 reads back as U
               mstatus_mpp  <= (csr_wdata[`MSTATUS_MPP_LO+:2] == 2'b11) ? MODE_M : MODE_U;
            end
            `CSR_MIE:      mie      <= csr_wdata & `MIE_MASK;
            `CSR_MTVEC:    mtvec    <= {csr_wdata[`XLEN-1:2], 2'b00};
            `CSR_MSCRATCH: mscratch <= csr_wdata;
            `CSR_MEPC:     mepc     <= {csr_wdata[`XLEN-1:2], 2'b00};
            `CSR_MCAUSE:   mcause   <= csr_wdata[4:0];
            `CSR_MTVAL:    mtval    <= csr_wdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= dec_valid;
      end
   end

   // ex_trap covers mret too, any change of flow
   always_ff @(posedge clk) begin
      if (dec_valid) begin
         ex_rd        <= dec_rd;
         ex_old_value <= csr_rdata;
         ex_trap      <= take_trap || do_mret;
         ex_target    <= take_trap ? mtvec : mepc;
      end
   end

endmodule
`default_nettype wire

// File: verilog/sys_result.sv
`default_nettype none
`include "priv_macros.svh"

module sys_result (
   input  wire               clk,
   input  wire               rstn,
   input  wire               ex_valid,
   input  wire [4:0]         ex_rd,
   input  wire [`XLEN-1:0]   ex_old_value,
   input  wire               ex_trap,
   input  wire [`XLEN-1:0]   ex_target,
   output logic              result_valid,
   output logic              rd_write,
   output logic [4:0]        rd_addr,
   output logic [`XLEN-1:0]  rd_data,
   output logic              redirect,
   output logic [`XLEN-1:0]  redirect_pc
);

   logic write_ok;

   // only a completed csr op with rd != x0 writes back
   assign write_ok = ex_valid && !ex_trap && (ex_rd != 5'd0);

   always_ff @(posedge clk) begin
      if (rstn) begin
         result_valid <= 1'b0;
         rd_write     <= 1'b0;
         redirect     <= 1'b0;
      end else begin
         result_valid <= ex_valid;
         rd_write     <= write_ok;
         redirect     <= ex_valid && ex_trap;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         rd_addr     <= ex_rd;
         rd_data     <= ex_old_value;
         redirect_pc <= ex_target;
      end
   end

endmodule
`default_nettype wire

// File: verilog/sys_unit_top.sv
`default_nettype none
`include "priv_macros.svh"

module sys_unit_top (
   input  wire                       clk,
   input  wire                       rstn,
   input  wire                       instr_valid,
   input  wire isa_pkg::instr_word_u instr_word,
   input  wire [`XLEN-1:0]           instr_pc,
   input  wire [`XLEN-1:0]           rs1_value,
   output wire                       result_valid,
   output wire                       rd_write,
   output wire [4:0]                 rd_addr,
   output wire [`XLEN-1:0]           rd_data,
   output wire                       redirect,
   output wire [`XLEN-1:0]           redirect_pc,
   output wire csr_pkg::priv_mode_t  cpu_mode
);
   import isa_pkg::*;
   import csr_pkg::*;

   // decode -> execute
   wire                   dec_valid;
   wire sys_op_t          dec_op;
   wire csr_addr_t        dec_csr;
   wire [4:0]             dec_rd;
   wire [`XLEN-1:0]       dec_operand;
   wire                   dec_csr_write;
   wire [`XLEN-1:0]       dec_pc;
   wire [`XLEN-1:0]       dec_word;

   // execute -> result
   wire                   ex_valid;
   wire [4:0]             ex_rd;
   wire [`XLEN-1:0]       ex_old_value;
   wire                   ex_trap;
   wire [`XLEN-1:0]       ex_target;

   sys_decode u_decode (
      .clk           (clk),
      .rstn          (rstn),
      .instr_valid   (instr_valid),
      .instr_word    (instr_word),
      .instr_pc      (instr_pc),
      .rs1_value     (rs1_value),
      .dec_valid     (dec_valid),
      .dec_op        (dec_op),
      .dec_csr       (dec_csr),
      .dec_rd        (dec_rd),
      .dec_operand   (dec_operand),
      .dec_csr_write (dec_csr_write),
      .dec_pc        (dec_pc),
      .dec_word      (dec_word)
   );

   csr_execute u_execute (
      .clk           (clk),
      .rstn          (rstn),
      .dec_valid     (dec_valid),
      .dec_op        (dec_op),
      .dec_csr       (dec_csr),
      .dec_rd        (dec_rd),
      .dec_operand   (dec_operand),
      .dec_csr_write (dec_csr_write),
      .dec_pc        (dec_pc),
      .dec_word      (dec_word),
      .ex_valid      (ex_valid),
      .ex_rd         (ex_rd),
      .ex_old_value  (ex_old_value),
      .ex_trap       (ex_trap),
      .ex_target     (ex_target),
      .cpu_mode      (cpu_mode)
   );

   sys_result u_result (
      .clk           (clk),
      .rstn          (rstn),
      .ex_valid      (ex_valid),
      .ex_rd         (ex_rd),
      .ex_old_value  (ex_old_value),
      .ex_trap       (ex_trap),
      .ex_target     (ex_target),
      .result_valid  (result_valid),
      .rd_write      (rd_write),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc)
   );

endmodule
`default_nettype wire

// File: testbench/sys_unit_assert.sv
`default_nettype none
`include "priv_macros.svh"

module sys_unit_assert (
   input wire             clk,
   input wire             rstn,
   input wire             instr_valid,
   input wire             result_valid,
   input wire             redirect,
   input wire             rd_write,
   input wire [4:0]       rd_addr,
   input wire [`XLEN-1:0] redirect_pc
);
   timeunit 1ns;
   timeprecision 1ps;

   int assert_errors = 0;

   // three register stages between input and result
   a_latency: assert property (@(posedge clk) disable iff (rstn)
      instr_valid |-> ##3 result_valid)
   else begin
      assert_errors++;
      $error("result_valid did not follow instr_valid by 3 cycles");
   end

   a_redirect_valid: assert property (@(posedge clk) disable iff (rstn)
      redirect |-> result_valid)
   else begin
      assert_errors++;
      $error("redirect high without result_valid");
   end

   // targets come from mtvec or mepc, both word aligned
   a_redirect_align: assert property (@(posedge clk) disable iff (rstn)
      redirect |-> (redirect_pc[1:0] == 2'b00))
   else begin
      assert_errors++;
      $error("redirect_pc not word aligned");
   end

   a_rd_nonzero: assert property (@(posedge clk) disable iff (rstn)
      rd_write |-> (rd_addr != 5'd0))
   else begin
      assert_errors++;
      $error("rd_write to x0");
   end

endmodule

bind sys_unit_top sys_unit_assert u_assert (
   .clk          (clk),
   .rstn         (rstn),
   .instr_valid  (instr_valid),
   .result_valid (result_valid),
   .redirect     (redirect),
   .rd_write     (rd_write),
   .rd_addr      (rd_addr),
   .redirect_pc  (redirect_pc)
);
`default_nettype wire

// File: testbench/tb_sys_unit.sv
`default_nettype none
`include "priv_macros.svh"

module tb_sys_unit;
   timeunit 1ns;
   timeprecision 1ps;
   import isa_pkg::*;
   import csr_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam logic [31:0] W_ECALL  = 32'h0000_0073;
   localparam logic [31:0] W_EBREAK = 32'h0010_0073;
   localparam logic [31:0] W_MRET   = 32'h3020_0073;

   typedef struct packed {
      logic             we;
      logic [4:0]       rd;
      logic [`XLEN-1:0] data;
      logic             redir;
      logic [`XLEN-1:0] pc;
      priv_mode_t       mode;
   } expect_t;

   logic             clk;
   logic             rstn;
   logic             instr_valid;
   instr_word_u      instr_word;
   logic [`XLEN-1:0] instr_pc;
   logic [`XLEN-1:0] rs1_value;
   wire              result_valid;
   wire              rd_write;
   wire [4:0]        rd_addr;
   wire [`XLEN-1:0]  rd_data;
   wire              redirect;
   wire [`XLEN-1:0]  redirect_pc;
   wire priv_mode_t  cpu_mode;

   // stimulus table
   string       tname[$];
   logic [31:0] tword[$];
   logic [31:0] tpc[$];
   logic [31:0] trs1[$];
   bit          trnd[$];
   bit          tidle[$];
   int          run_cycles = 0;
   bit          table_ready = 0;

   expect_t     exp_q[$];
   string       exp_name_q[$];
   int          due_q[$];
   int          cycle_count = 0;
   int          mismatch_count = 0;
   int          protocol_count = 0;
   priv_mode_t  last_mode;
   logic [31:0] lfsr_state;

   // reference model state
   priv_mode_t  m_mode;
   logic        m_mie;
   logic        m_mpie;
   logic [1:0]  m_mpp;
   logic [31:0] m_mie_reg;
   logic [31:0] m_mtvec;
   logic [31:0] m_mscratch;
   logic [31:0] m_mepc;
   logic [4:0]  m_mcause;
   logic [31:0] m_mtval;

   sys_unit_top dut0 (
      .clk          (clk),
      .rstn         (rstn),
      .instr_valid  (instr_valid),
      .instr_word   (instr_word),
      .instr_pc     (instr_pc),
      .rs1_value    (rs1_value),
      .result_valid (result_valid),
      .rd_write     (rd_write),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .cpu_mode     (cpu_mode)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // stimulus helpers

   // galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] w;
      int          b;
      w = '0;
      for (b = 0; b < 32; b++) begin
         w = {w[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return w;
   endfunction

   function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] csr,
                                            input logic [4:0] src, input logic [4:0] rd);
      return {csr, src, f3, rd, `OPC_SYSTEM};
   endfunction

   task automatic add_entry(input string name, input logic [31:0] word,
                            input logic [31:0] rs1, input bit rnd, input bit idle);
      tpc.push_back(32'h0000_0100 + 4 * tname.size());
      tname.push_back(name);
      tword.push_back(word);
      trs1.push_back(rs1);
      trnd.push_back(rnd);
      tidle.push_back(idle);
      run_cycles += idle ? 2 : 1;
   endtask

   task automatic build_table();
      // funct3 1/2/3 register forms, 5/6/7 immediate forms
      add_entry("csrrw mscratch", csr_word(3'd1, `CSR_MSCRATCH, 5'd1, 5'd5), '0, 1, 0);
      add_entry("csrrs mscratch", csr_word(3'd2, `CSR_MSCRATCH, 5'd2, 5'd6), '0, 1, 0);
      add_entry("csrrc mscratch", csr_word(3'd3, `CSR_MSCRATCH, 5'd3, 5'd7), '0, 1, 0);
      add_entry("csrrs x0 mscratch", csr_word(3'd2, `CSR_MSCRATCH, 5'd0, 5'd8), '0, 1, 0);
      add_entry("csrrc x0 mscratch", csr_word(3'd3, `CSR_MSCRATCH, 5'd0, 5'd9), '0, 1, 1);
      add_entry("csrrwi mscratch", csr_word(3'd5, `CSR_MSCRATCH, 5'h15, 5'd10), '0, 1, 0);
      add_entry("csrrsi mscratch", csr_word(3'd6, `CSR_MSCRATCH, 5'h0a, 5'd11), '0, 0, 0);
      add_entry("csrrci mscratch", csr_word(3'd7, `CSR_MSCRATCH, 5'h03, 5'd12), '0, 0, 0);
      add_entry("csrrci 0 mscratch", csr_word(3'd7, `CSR_MSCRATCH, 5'h00, 5'd13), '0, 0, 0);
      add_entry("read mscratch", csr_word(3'd2, `CSR_MSCRATCH, 5'd0, 5'd14), '0, 0, 1);
      // write masks
      add_entry("mstatus ones", csr_word(3'd1, `CSR_MSTATUS, 5'd1, 5'd1), 32'hffff_ffff, 0, 0);
      add_entry("mstatus mpp 01", csr_word(3'd1, `CSR_MSTATUS, 5'd1, 5'd2), 32'h888, 0, 0);
      add_entry("read mstatus", csr_word(3'd2, `CSR_MSTATUS, 5'd0, 5'd3), '0, 0, 0);
      add_entry("write mie", csr_word(3'd1, `CSR_MIE, 5'd1, 5'd4), 32'hffff_ffff, 0, 0);
      add_entry("read mie", csr_word(3'd2, `CSR_MIE, 5'd0, 5'd4), '0, 0, 0);
      add_entry("mtvec rd0", csr_word(3'd1, `CSR_MTVEC, 5'd1, 5'd0), 32'h0000_1003, 0, 0);
      add_entry("write mepc", csr_word(3'd1, `CSR_MEPC, 5'd1, 5'd5), 32'h0000_2007, 0, 0);
      add_entry("read mepc mask", csr_word(3'd2, `CSR_MEPC, 5'd0, 5'd5), '0, 0, 0);
      add_entry("read mtvec", csr_word(3'd2, `CSR_MTVEC, 5'd0, 5'd6), '0, 0, 1);
      // constants, illegal accesses and traps
      add_entry("read misa", csr_word(3'd2, `CSR_MISA, 5'd0, 5'd7), '0, 0, 0);
      add_entry("read mhartid", csr_word(3'd2, `CSR_MHARTID, 5'd0, 5'd8), '0, 0, 0);
      add_entry("write mhartid", csr_word(3'd1, `CSR_MHARTID, 5'd1, 5'd8), '0, 1, 0);
      add_entry("read mcause", csr_word(3'd2, `CSR_MCAUSE, 5'd0, 5'd9), '0, 0, 0);
      add_entry("read mtval", csr_word(3'd2, `CSR_MTVAL, 5'd0, 5'd9), '0, 0, 0);
      add_entry("read mepc", csr_word(3'd2, `CSR_MEPC, 5'd0, 5'd9), '0, 0, 0);
      add_entry("unknown csr", csr_word(3'd2, 12'h7c0, 5'd0, 5'd10), '0, 0, 1);
      add_entry("ecall m", W_ECALL, '0, 0, 0);
      add_entry("read mcause ecall", csr_word(3'd2, `CSR_MCAUSE, 5'd0, 5'd13), '0, 0, 0);
      add_entry("ebreak", W_EBREAK, '0, 0, 0);
      add_entry("read mcause ebreak", csr_word(3'd2, `CSR_MCAUSE, 5'd0, 5'd13), '0, 0, 0);
      add_entry("read mtval ebreak", csr_word(3'd2, `CSR_MTVAL, 5'd0, 5'd14), '0, 0, 0);
      add_entry("read mstatus trap", csr_word(3'd2, `CSR_MSTATUS, 5'd0, 5'd3), '0, 0, 0);
      // user mode round trips
      add_entry("mstatus mpp u", csr_word(3'd1, `CSR_MSTATUS, 5'd1, 5'd0), 32'h80, 0, 0);
      add_entry("mret to u", W_MRET, '0, 0, 0);
      add_entry("csr in u", csr_word(3'd2, `CSR_MSCRATCH, 5'd0, 5'd11), '0, 0, 0);
      add_entry("mret to u again", W_MRET, '0, 0, 0);
      add_entry("mret in u", W_MRET, '0, 0, 0);
      add_entry("mret to u third", W_MRET, '0, 0, 0);
      add_entry("ecall u", W_ECALL, '0, 0, 0);
      add_entry("read mcause u", csr_word(3'd2, `CSR_MCAUSE, 5'd0, 5'd12), '0, 0, 0);
      add_entry("addi opcode", 32'h0000_0013, '0, 0, 0);
      add_entry("wfi", 32'h1050_0073, '0, 0, 0);
      table_ready = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // reference model stepping one instruction at a time
   task automatic model_step(input logic [31:0] w, input logic [31:0] pc,
                             input logic [31:0] rs1, output expect_t e);
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic [4:0]  src;
      logic [11:0] csr;
      logic        is_csr;
      logic        known;
      logic        wr;
      logic        illegal;
      logic [4:0]  cause;
      logic [31:0] old;
      logic [31:0] opnd;
      logic [31:0] nv;
      rd = w[11:7];
      f3 = w[14:12];
      src = w[19:15];
      csr = w[31:20];
      is_csr = (w[6:0] == 7'b1110011) && (f3[1:0] != 2'b00);
      opnd = f3[2] ? {27'd0, src} : rs1;
      wr = (f3[1:0] == 2'b01) || (src != 5'd0);
      known = 1'b1;
      old = '0;
      case (csr)
         12'h300: old = {19'd0, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
         12'h301: old = 32'h4010_0100;
         12'h304: old = m_mie_reg;
         12'h305: old = m_mtvec;
         12'h340: old = m_mscratch;
         12'h341: old = m_mepc;
         12'h342: old = {27'd0, m_mcause};
         12'h343: old = m_mtval;
         12'hf14: old = '0;
         default: known = 1'b0;
      endcase
      illegal = 1'b0;
      cause = '0;
      e = '0;
      if (is_csr) begin
         illegal = !known || (m_mode != MODE_M) || ((csr[11:10] == 2'b11) && wr);
      end else if (w == W_ECALL) begin
         cause = (m_mode == MODE_M) ? 5'd11 : 5'd8;
      end else if (w == W_EBREAK) begin
         cause = 5'd3;
      end else if (w == W_MRET) begin
         illegal = (m_mode != MODE_M);
      end else begin
         illegal = 1'b1;
      end
      if (illegal) begin
         cause = 5'd2;
      end
      if (cause != 5'd0) begin
         e.redir = 1'b1;
         e.pc = m_mtvec;
         m_mepc = pc;
         m_mcause = cause;
         m_mtval = illegal ? w : '0;
         m_mpie = m_mie;
         m_mie = 1'b0;
         m_mpp = m_mode;
         m_mode = MODE_M;
      end else if (!is_csr) begin
         e.redir = 1'b1;
         e.pc = m_mepc;
         m_mode = (m_mpp == 2'b11) ? MODE_M : MODE_U;
         m_mie = m_mpie;
         m_mpie = 1'b1;
         m_mpp = 2'b00;
      end else begin
         e.we = (rd != 5'd0);
         e.rd = rd;
         e.data = old;
         case (f3[1:0])
            2'b01: nv = opnd;
            2'b10: nv = old | opnd;
            default: nv = old & ~opnd;
         endcase
         if (wr) begin
            case (csr)
               12'h300: begin
                  m_mie = nv[3];
                  m_mpie = nv[7];
                  m_mpp = (nv[12:11] == 2'b11) ? 2'b11 : 2'b00;
               end
               12'h304: m_mie_reg = nv & 32'h0000_0888;
               12'h305: m_mtvec = {nv[31:2], 2'b00};
               12'h340: m_mscratch = nv;
               12'h341: m_mepc = {nv[31:2], 2'b00};
               12'h342: m_mcause = nv[4:0];
               12'h343: m_mtval = nv;
               default: ;
            endcase
         end
      end
      e.mode = m_mode;
   endtask

   //////////////////////////////////////////////////
   // compare tasks
   task automatic check_write(input string name, input logic exp_we,
                              input logic [4:0] exp_rd, input logic [`XLEN-1:0] exp_data);
      if (rd_write !== exp_we) begin
         $display("mismatch %s rd_write expected %0b actual %0b", name, exp_we, rd_write);
         mismatch_count++;
      end else if (exp_we && ((rd_addr !== exp_rd) || (rd_data !== exp_data))) begin
         $display("mismatch %s rd expected x%0d=%h actual x%0d=%h",
                  name, exp_rd, exp_data, rd_addr, rd_data);
         mismatch_count++;
      end
   endtask

   task automatic check_flow(input string name, input logic exp_redir,
                             input logic [`XLEN-1:0] exp_pc, input priv_mode_t exp_mode,
                             input priv_mode_t act_mode);
      if ((redirect !== exp_redir) || (exp_redir && (redirect_pc !== exp_pc))) begin
         $display("mismatch %s redirect expected %0b/%h actual %0b/%h",
                  name, exp_redir, exp_pc, redirect, redirect_pc);
         mismatch_count++;
      end
      if (act_mode !== exp_mode) begin
         $display("mismatch %s mode expected %0d actual %0d", name, exp_mode, act_mode);
         mismatch_count++;
      end
   endtask

   // outputs sampled on the falling edge
   // mode is taken one cycle before the result, right after execute
   always @(negedge clk) begin
      cycle_count++;
      if (!rstn) begin
         if (instr_valid) begin
            due_q.push_back(cycle_count + 3);
         end
         if ((due_q.size() > 0) && (due_q[0] == cycle_count)) begin
            if (result_valid !== 1'b1) begin
               $display("no result_valid for test %s 3 cycles after its input", exp_name_q[0]);
               protocol_count++;
            end else begin
               check_write(exp_name_q[0], exp_q[0].we, exp_q[0].rd, exp_q[0].data);
               check_flow(exp_name_q[0], exp_q[0].redir, exp_q[0].pc, exp_q[0].mode, last_mode);
            end
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            void'(exp_name_q.pop_front());
         end else if (result_valid === 1'b1) begin
            $display("result_valid high with no instruction due");
            protocol_count++;
         end
         last_mode = cpu_mode;
      end
   end

   //////////////////////////////////////////////////
   // main sequence
   initial begin
      expect_t     e;
      logic [31:0] rs1;
      int          i;
      rstn = 1'b1;
      instr_valid = 1'b0;
      instr_word = '0;
      instr_pc = '0;
      rs1_value = '0;
      lfsr_state = 32'ha9f3_0ef1;
      m_mode = MODE_M;
      m_mie = 1'b0;
      m_mpie = 1'b0;
      m_mpp = 2'b00;
      m_mie_reg = '0;
      m_mtvec = '0;
      m_mscratch = '0;
      m_mepc = '0;
      m_mcause = '0;
      m_mtval = '0;
      build_table();
      repeat (4) @(posedge clk);
      rstn <= 1'b0;
      for (i = 0; i < tname.size(); i++) begin
         @(posedge clk);
         rs1 = trnd[i] ? random_word() : trs1[i];
         model_step(tword[i], tpc[i], rs1, e);
         exp_q.push_back(e);
         exp_name_q.push_back(tname[i]);
         instr_valid <= 1'b1;
         instr_word <= tword[i];
         instr_pc <= tpc[i];
         rs1_value <= rs1;
         if (tidle[i]) begin
            @(posedge clk);
            instr_valid <= 1'b0;
         end
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      $display("errors: %0d mismatch, %0d protocol, %0d assertion",
               mismatch_count, protocol_count, dut0.u_assert.assert_errors);
      if ((mismatch_count + protocol_count + dut0.u_assert.assert_errors) == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog sized from the table, reset and pipeline depth
   initial begin
      wait (table_ready);
      #(CLK_PERIOD * (run_cycles + 4 + 4 + 10));
      $display("timeout, the run did not finish within %0d cycles", run_cycles + 18);
      $display("Result: FAILED");
      $finish;
   end

endmodule
`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/csr_pkg.sv
verilog/sys_decode.sv
verilog/csr_execute.sv
verilog/sys_result.sv
verilog/sys_unit_top.sv
testbench/sys_unit_assert.sv
testbench/tb_sys_unit.sv
